/* design/biphase_front.sv */
/*
  biphase-L to NRZ on I plus realignment of Q
  chip pairing is not recovered from the data; the first symbol strobe
  after biphase is enabled is taken as the first chip of a pair
  Q is not biphase decoded, only registered on the bit strobe
*/

`timescale 1ns/1ps

module biphase_front (
  input  logic                          clk,
  input  logic                          rs,
  input  logic                          symb_clk_en_i,
  input  logic                          biphase_i,
  input  logic                          symb_i_i,
  input  logic                          symb_q_i,
  output logic                          bit_en_o,
  output logic [bitdec_pkg::NUM_CH-1:0] nrz_ch_o,
  output logic [bitdec_pkg::NUM_CH-1:0] last_ch_o
);

  // high while the next strobe brings the second chip
  logic phase;
  // first chip of the pair, which is the NRZ bit
  logic first_chip;
  // effective bit strobe
  logic bit_stb;

  // always enabled outside biphase mode
  assign bit_en_o = ~biphase_i | phase;
  assign bit_stb  = symb_clk_en_i & bit_en_o;

  // ------------------------------
  // chip pair tracking
  // ------------------------------

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      phase      <= 1'b0;
      first_chip <= 1'b0;
    end
    else if (symb_clk_en_i)
    begin
      // phase parked at zero when not in biphase
      phase <= biphase_i & ~phase;
      // grab the leading chip of each pair
      if (!phase)
        first_chip <= symb_i_i;
    end
  end

  // ------------------------------
  // NRZ capture and previous bits
  // ------------------------------

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      nrz_ch_o  <= '0;
      last_ch_o <= '0;
    end
    else if (bit_stb)
    begin
      // Q takes the same single register as I so both stay aligned
      nrz_ch_o  <= {symb_q_i, biphase_i ? first_chip : symb_i_i};
      // previous bit per channel for mark/space decode
      last_ch_o <= nrz_ch_o;
    end
  end

endmodule

/* design/bit_decoder_top.sv */
/*
  bit decoder top, all logic on clk with async active-high reset
  symb_clk_2x_en_i must pulse twice per symbol, once with symb_clk_en_i
  no back-pressure; outputs are valid at each strobe only
*/

`timescale 1ns/1ps

module bit_decoder_top #(
  parameter logic [12:0] REG_ADDR = 13'h0040
) (
  input  logic        clk,
  input  logic        rs,
  input  logic        en_i,
  input  logic        wr0_i,
  input  logic        wr1_i,
  input  logic [12:0] addr_i,
  input  logic [15:0] din_i,
  output logic [15:0] dout_o,
  input  logic        symb_clk_en_i,
  input  logic        symb_clk_2x_en_i,
  input  logic        symb_i_i,
  input  logic        symb_q_i,
  output logic        dout_i_o,
  output logic        dout_q_o,
  output logic        cout_o,
  output logic        symb_clk_o,
  output logic        fifo_rs_o,
  output logic        clk_inv_o,
  output logic        bypass_fifo_o,
  output logic        input_sel_o
);

  logic [15:0]                   ctl;
  logic                          biphase;
  logic                          clk_sel;
  logic                          data_inv;
  logic                          derand;
  logic                          demux;
  logic                          swap;
  bitdec_pkg::code_mode_e        mode;
  logic                          bit_en;
  logic [bitdec_pkg::NUM_CH-1:0] nrz_ch;
  logic [bitdec_pkg::NUM_CH-1:0] last_ch;
  logic [bitdec_pkg::NUM_CH-1:0] dec_ch;
  logic                          sel_i;
  logic                          sel_q;
  logic                          shift_en;

  // ------------------------------
  // control register and fields
  // ------------------------------

  decoder_regs #(
    .REG_ADDR (REG_ADDR)
  ) u_regs (
    .clk    (clk),
    .rs     (rs),
    .en_i   (en_i),
    .wr0_i  (wr0_i),
    .wr1_i  (wr1_i),
    .addr_i (addr_i),
    .din_i  (din_i),
    .dout_o (dout_o),
    .ctl_o  (ctl)
  );

  // FIFO and input selector live outside, these only pass out
  assign fifo_rs_o     = ctl[bitdec_pkg::CTL_FIFO_RS];
  assign clk_inv_o     = ctl[bitdec_pkg::CTL_CLK_INV];
  assign bypass_fifo_o = ctl[bitdec_pkg::CTL_BYPASS_FIFO];
  assign input_sel_o   = ctl[bitdec_pkg::CTL_INPUT_SEL];
  assign clk_sel       = ctl[bitdec_pkg::CTL_CLK_SEL];
  assign data_inv      = ctl[bitdec_pkg::CTL_DATA_INV];
  assign derand        = ctl[bitdec_pkg::CTL_DERAND];
  assign demux         = ctl[bitdec_pkg::CTL_DEMUX];
  assign swap          = ctl[bitdec_pkg::CTL_SWAP];
  assign biphase       = ctl[bitdec_pkg::CTL_BIPHASE];
  assign mode          = bitdec_pkg::code_mode_e'(ctl[bitdec_pkg::CTL_MODE_LO +: 2]);

  // ------------------------------
  // data path
  // ------------------------------

  biphase_front u_front (
    .clk           (clk),
    .rs            (rs),
    .symb_clk_en_i (symb_clk_en_i),
    .biphase_i     (biphase),
    .symb_i_i      (symb_i_i),
    .symb_q_i      (symb_q_i),
    .bit_en_o      (bit_en),
    .nrz_ch_o      (nrz_ch),
    .last_ch_o     (last_ch)
  );

  // one decoder per channel
  for (genvar g = 0; g < bitdec_pkg::NUM_CH; g++)
  begin : g_dec
    line_decoder u_dec (
      .clk        (clk),
      .rs         (rs),
      .clk_en_i   (symb_clk_en_i),
      .bit_en_i   (bit_en),
      .mode_i     (mode),
      .din_i      (nrz_ch[g]),
      .last_din_i (last_ch[g]),
      .dout_o     (dec_ch[g])
    );
  end

  channel_combiner u_comb (
    .clk              (clk),
    .rs               (rs),
    .symb_clk_en_i    (symb_clk_en_i),
    .symb_clk_2x_en_i (symb_clk_2x_en_i),
    .bit_en_i         (bit_en),
    .biphase_i        (biphase),
    .clk_sel_i        (clk_sel),
    .swap_i           (swap),
    .demux_i          (demux),
    .dec_ch_i         (dec_ch),
    .sel_i_o          (sel_i),
    .sel_q_o          (sel_q),
    .shift_en_o       (shift_en),
    .cout_o           (cout_o),
    .symb_clk_o       (symb_clk_o)
  );

  derandomizer u_derand (
    .clk        (clk),
    .rs         (rs),
    .shift_en_i (shift_en),
    .derand_i   (derand),
    .data_inv_i (data_inv),
    .sel_i_i    (sel_i),
    .sel_q_i    (sel_q),
    .dout_i_o   (dout_i_o),
    .dout_q_o   (dout_q_o)
  );

endmodule

/* design/bitdec_pkg.sv */
/*
  shared constants for the telemetry bit decoder
  channel 0 is I and channel 1 is Q
  control register is 16 bits, bits 10..12 and 15 unused and read as zero
*/

package bitdec_pkg;

  // ------------------------------
  // channel count
  // ------------------------------

  // I and Q symbol channels
  localparam int NUM_CH = 2;

  // ------------------------------
  // line code selection
  // ------------------------------

  // NRZ_L passes the bit, NRZ_M is the transition, NRZ_S its complement
  // value 3 is not a valid code
  typedef enum logic [1:0] {
    NRZ_L = 2'd0,
    NRZ_M = 2'd1,
    NRZ_S = 2'd2
  } code_mode_e;

  // ------------------------------
  // control register layout
  // ------------------------------

  localparam int CTL_FIFO_RS     = 0;
  localparam int CTL_CLK_INV     = 1;
  localparam int CTL_CLK_SEL     = 2;
  localparam int CTL_DATA_INV    = 3;
  localparam int CTL_DERAND      = 4;
  localparam int CTL_DEMUX       = 5;
  localparam int CTL_SWAP        = 6;
  localparam int CTL_BIPHASE     = 7;
  // low bit of the 2-bit code mode field, bits 9:8
  localparam int CTL_MODE_LO     = 8;
  localparam int CTL_BYPASS_FIFO = 13;
  localparam int CTL_INPUT_SEL   = 14;

  // straight NRZ-L, no inversion, no derandomizing
  localparam logic [15:0] CTL_RESET = 16'h0000;

endpackage

/* design/channel_combiner.sv */
/*
  straight, swapped or QPSK-serial channel selection
  serial mode emits the I bit on the on-symbol 2x strobe, Q on the next one
  swap also exchanges the serial order
  biphase together with serial mode is not supported
*/

`timescale 1ns/1ps

module channel_combiner (
  input  logic                          clk,
  input  logic                          rs,
  input  logic                          symb_clk_en_i,
  input  logic                          symb_clk_2x_en_i,
  input  logic                          bit_en_i,
  input  logic                          biphase_i,
  input  logic                          clk_sel_i,
  input  logic                          swap_i,
  input  logic                          demux_i,
  input  logic [bitdec_pkg::NUM_CH-1:0] dec_ch_i,
  output logic                          sel_i_o,
  output logic                          sel_q_o,
  output logic                          shift_en_o,
  output logic                          cout_o,
  output logic                          symb_clk_o
);

  // half-symbol phase, high between on-symbol strobe and the next 2x strobe
  logic mux_phase;
  // second serial bit parked for the mid-symbol strobe
  logic ser_hold;
  logic first_bit;
  logic second_bit;
  logic ser_next;

  // swap picks which channel goes first or onto the I line
  assign first_bit  = swap_i ? dec_ch_i[1] : dec_ch_i[0];
  assign second_bit = swap_i ? dec_ch_i[0] : dec_ch_i[1];

  // on-symbol strobe starts a new serial pair
  assign ser_next = symb_clk_en_i ? first_bit : ser_hold;

  // 2x rate when serial, the effective bit strobe otherwise
  assign shift_en_o = demux_i ? symb_clk_2x_en_i : (symb_clk_en_i & bit_en_i);

  // ------------------------------
  // bit clock and symbol square wave
  // ------------------------------

  // biphase clocks once per chip pair
  assign cout_o = biphase_i ? (symb_clk_en_i & bit_en_i) :
                  (clk_sel_i ? symb_clk_en_i : symb_clk_2x_en_i);

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
      mux_phase <= 1'b0;
    else if (symb_clk_2x_en_i)
      mux_phase <= symb_clk_en_i | ~mux_phase;
  end

  assign symb_clk_o = mux_phase;

  // ------------------------------
  // output selection register
  // ------------------------------

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      sel_i_o  <= 1'b0;
      sel_q_o  <= 1'b0;
      ser_hold <= 1'b0;
    end
    else if (shift_en_o)
    begin
      if (demux_i)
      begin
        // serial bit on I, its complement on Q
        sel_i_o <= ser_next;
        sel_q_o <= ~ser_next;
        if (symb_clk_en_i)
          ser_hold <= second_bit;
      end
      else
      begin
        sel_i_o <= first_bit;
        sel_q_o <= second_bit;
      end
    end
  end

endmodule

/* design/decoder_regs.sv */
/*
  16-bit control register on a byte-write bus clocked by clk
  unused bits are dropped on write and read back zero
  an invalid code mode (3) is stored as NRZ-L
*/

`timescale 1ns/1ps

module decoder_regs #(
  parameter logic [12:0] REG_ADDR = 13'h0040
) (
  input  logic        clk,
  input  logic        rs,
  input  logic        en_i,
  input  logic        wr0_i,
  input  logic        wr1_i,
  input  logic [12:0] addr_i,
  input  logic [15:0] din_i,
  output logic [15:0] dout_o,
  output logic [15:0] ctl_o
);

  // bits with a function
  localparam logic [15:0] CTL_USED =
    16'(1 << bitdec_pkg::CTL_FIFO_RS)  | 16'(1 << bitdec_pkg::CTL_CLK_INV) |
    16'(1 << bitdec_pkg::CTL_CLK_SEL)  | 16'(1 << bitdec_pkg::CTL_DATA_INV) |
    16'(1 << bitdec_pkg::CTL_DERAND)   | 16'(1 << bitdec_pkg::CTL_DEMUX) |
    16'(1 << bitdec_pkg::CTL_SWAP)     | 16'(1 << bitdec_pkg::CTL_BIPHASE) |
    16'(3 << bitdec_pkg::CTL_MODE_LO)  | 16'(1 << bitdec_pkg::CTL_BYPASS_FIFO) |
    16'(1 << bitdec_pkg::CTL_INPUT_SEL);

  logic        hit;
  logic [15:0] wdata;

  assign hit = en_i && (addr_i == REG_ADDR);

  // write data cleanup
  always_comb
  begin
    wdata = din_i & CTL_USED;
    if (wdata[bitdec_pkg::CTL_MODE_LO +: 2] != bitdec_pkg::NRZ_M &&
        wdata[bitdec_pkg::CTL_MODE_LO +: 2] != bitdec_pkg::NRZ_S)
      wdata[bitdec_pkg::CTL_MODE_LO +: 2] = bitdec_pkg::NRZ_L;
  end

  // byte lanes written independently
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
      ctl_o <= bitdec_pkg::CTL_RESET;
    else if (hit)
    begin
      if (wr0_i)
        ctl_o[7:0] <= wdata[7:0];
      if (wr1_i)
        ctl_o[15:8] <= wdata[15:8];
    end
  end

  // combinational readback, zero when not selected
  assign dout_o = hit ? ctl_o : 16'h0000;

endmodule

/* design/derandomizer.sv */
/*
  derandomizer for 1 + x^14 + x^15, self-synchronizing
  output is valid after 15 bits have filled the shift register
  output register is loaded in every mode, so latency never changes
*/

`timescale 1ns/1ps

module derandomizer (
  input  logic clk,
  input  logic rs,
  input  logic shift_en_i,
  input  logic derand_i,
  input  logic data_inv_i,
  input  logic sel_i_i,
  input  logic sel_q_i,
  output logic dout_i_o,
  output logic dout_q_o
);

  // past received bits, [0] newest
  logic [14:0] shreg;
  // received bit with the polynomial taps removed
  logic        derand_bit;
  logic        out_i;
  logic        out_q;

  assign derand_bit = sel_i_i ^ shreg[14] ^ shreg[13];

  // ------------------------------
  // shift register and output stage
  // ------------------------------

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      shreg <= '0;
      out_i <= 1'b0;
      out_q <= 1'b0;
    end
    else if (shift_en_i)
    begin
      // history runs even when bypassed
      shreg <= {shreg[13:0], sel_i_i};
      // derandomized bit drives both lines
      out_i <= derand_i ? derand_bit : sel_i_i;
      out_q <= derand_i ? derand_bit : sel_q_i;
    end
  end

  // polarity flip after the register
  assign dout_i_o = out_i ^ data_inv_i;
  assign dout_q_o = out_q ^ data_inv_i;

endmodule

/* design/line_decoder.sv */
/*
  mark/space decode of one channel
  mode value 3 falls back to NRZ-L
  advances only on symbol strobe with bit enable
*/

`timescale 1ns/1ps

module line_decoder (
  input  logic                   clk,
  input  logic                   rs,
  input  logic                   clk_en_i,
  input  logic                   bit_en_i,
  input  bitdec_pkg::code_mode_e mode_i,
  input  logic                   din_i,
  input  logic                   last_din_i,
  output logic                   dout_o
);

  // transition between current and previous NRZ bit
  logic trans;

  assign trans = din_i ^ last_din_i;

  // ------------------------------
  // decode register
  // ------------------------------

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      dout_o <= 1'b0;
    end
    else if (clk_en_i && bit_en_i)
    begin
      case (mode_i)
        // mark, a change means one
        bitdec_pkg::NRZ_M:
          dout_o <= trans;
        // space, a change means zero
        bitdec_pkg::NRZ_S:
          dout_o <= ~trans;
        // level code, straight through
        default:
          dout_o <= din_i;
      endcase
    end
  end

endmodule

/* list.f */
design/bitdec_pkg.sv
design/biphase_front.sv
design/line_decoder.sv
design/channel_combiner.sv
design/derandomizer.sv
design/decoder_regs.sv
design/bit_decoder_top.sv
sim/tb_bit_decoder.sv

/* run_sim.sh */
#!/bin/bash
# build and run the bit decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_bit_decoder -f list.f -Mdir obj_dir \
  > build.log 2>&1 \
  && ./obj_dir/Vtb_bit_decoder > sim.log 2>&1 \
  || echo "build or run returned an error, see build.log and sim.log"
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim/tb_bit_decoder.sv */
/*
  testbench for the bit decoder top level
  strobes: 2x every 4 clocks, symbol strobe on every second 2x strobe
  every test starts from reset with the mode written before strobes run
  straight modes compare 4 strobes behind, serial mode 6 half-symbols behind
*/

`timescale 1ns/1ps

module tb_bit_decoder;

  localparam logic [12:0] ADDR      = 13'h0040;
  localparam int          MAX_SYM   = 512;
  localparam int          WATCHDOG  = 200000;

  logic        clk;
  logic        rs;
  logic        en;
  logic        wr0;
  logic        wr1;
  logic [12:0] addr;
  logic [15:0] din;
  logic [15:0] dout;
  logic        symb_en;
  logic        symb_2x;
  logic        sym_i;
  logic        sym_q;
  logic        dout_i;
  logic        dout_q;
  logic        cout;
  logic        symb_clk;
  logic        fifo_rs;
  logic        clk_inv;
  logic        bypass_fifo;
  logic        input_sel;

  // effective strobe as the tb sees it, set with the strobes
  logic        eff_stb;
  bit          gen_on;
  bit          run_on;
  bit          stuck;
  int          n_sym;
  int          n_eff;
  int          cmp_chk;
  int          cmp_err;
  int          reg_err;
  int          tests_run;
  int          tests_failed;
  // expected symbol square wave
  logic        exp_sclk;

  // symbol history per effective strobe
  logic        si [0:MAX_SYM-1];
  logic        sq [0:MAX_SYM-1];
  // plain I bits before scrambling
  logic        pl [0:MAX_SYM-1];

  // mode copy for the reference model
  logic [1:0]  m_mode;
  bit          m_swap;
  bit          m_inv;
  bit          m_derand;
  bit          m_serial;
  bit          m_biphase;
  bit          m_scramble;
  int          m_skip;

  bit_decoder_top #(
    .REG_ADDR (ADDR)
  ) u_dut (
    .clk              (clk),
    .rs               (rs),
    .en_i             (en),
    .wr0_i            (wr0),
    .wr1_i            (wr1),
    .addr_i           (addr),
    .din_i            (din),
    .dout_o           (dout),
    .symb_clk_en_i    (symb_en),
    .symb_clk_2x_en_i (symb_2x),
    .symb_i_i         (sym_i),
    .symb_q_i         (sym_q),
    .dout_i_o         (dout_i),
    .dout_q_o         (dout_q),
    .cout_o           (cout),
    .symb_clk_o       (symb_clk),
    .fifo_rs_o        (fifo_rs),
    .clk_inv_o        (clk_inv),
    .bypass_fifo_o    (bypass_fifo),
    .input_sel_o      (input_sel)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // reference model
  // ------------------------------

  // zero before the first symbol, like the reset registers
  function automatic logic sym_at(int ch, int k);
    if (k < 0)
      return 1'b0;
    return (ch == 0) ? si[k] : sq[k];
  endfunction

  function automatic logic dec_bit(int ch, int k);
    logic t;
    t = sym_at(ch, k) ^ sym_at(ch, k - 1);
    case (m_mode)
      2'd1: return t;
      2'd2: return ~t;
      default: return sym_at(ch, k);
    endcase
  endfunction

  // channel put on the I line, or sent first when serial
  function automatic logic first_bit(int k);
    return m_swap ? dec_bit(1, k) : dec_bit(0, k);
  endfunction

  function automatic logic second_bit(int k);
    return m_swap ? dec_bit(0, k) : dec_bit(1, k);
  endfunction

  // expected {dout_q, dout_i} for strobe index k
  function automatic logic [1:0] ref_out(int k);
    logic a;
    logic b;
    if (m_serial)
    begin
      // I first, then Q, complement on the Q line
      a = (k % 2 == 0) ? first_bit(k / 2) : second_bit(k / 2);
      b = ~a;
    end
    else
    begin
      a = first_bit(k);
      b = second_bit(k);
      if (m_derand)
      begin
        // scrambled I data comes back out on both lines
        a = pl[k];
        b = a;
      end
    end
    return {b ^ m_inv, a ^ m_inv};
  endfunction

  // ------------------------------
  // strobe and symbol generator
  // ------------------------------

  initial
  begin
    int   cyc;
    int   chip;
    logic cur_b;
    logic cur_q;
    logic u;
    symb_en = 1'b0;
    symb_2x = 1'b0;
    sym_i   = 1'b0;
    sym_q   = 1'b0;
    eff_stb = 1'b0;
    cyc     = 0;
    chip    = 0;
    cur_b   = 1'b0;
    cur_q   = 1'b0;
    n_sym   = 0;
    forever
    begin
      @(negedge clk);
      if (!gen_on)
      begin
        symb_en = 1'b0;
        symb_2x = 1'b0;
        eff_stb = 1'b0;
        cyc     = 0;
        chip    = 0;
        n_sym   = 0;
      end
      else
      begin
        symb_2x = (cyc % 4 == 0);
        symb_en = (cyc % 8 == 0);
        eff_stb = 1'b0;
        if (symb_en && m_biphase)
        begin
          // biphase-L pair is the bit then its complement
          if (chip % 2 == 0)
          begin
            cur_b     = 1'($urandom());
            cur_q     = 1'($urandom());
            si[n_sym] = cur_b;
            sq[n_sym] = cur_q;
            sym_i     = cur_b;
          end
          else
          begin
            sym_i   = ~cur_b;
            eff_stb = 1'b1;
            n_sym++;
          end
          sym_q = cur_q;
          chip++;
        end
        else if (symb_en)
        begin
          cur_b     = 1'($urandom());
          cur_q     = 1'($urandom());
          pl[n_sym] = cur_b;
          // scrambler with the same polynomial
          if (m_scramble)
          begin
            u     = cur_b;
            cur_b = u ^ sym_at(0, n_sym - 14) ^ sym_at(0, n_sym - 15);
          end
          si[n_sym] = cur_b;
          sq[n_sym] = cur_q;
          sym_i     = cur_b;
          sym_q     = cur_q;
          eff_stb   = 1'b1;
          n_sym++;
        end
        // serial output moves at the 2x rate
        if (m_serial)
          eff_stb = symb_2x;
        cyc++;
      end
    end
  end

  // ------------------------------
  // comparator
  // ------------------------------

  // reads outputs before the edge updates them
  always @(posedge clk)
  begin
    int         k;
    logic [1:0] exp_out;
    if (!run_on)
    begin
      n_eff    = 0;
      exp_sclk = 1'b0;
    end
    else
    begin
      if (symb_clk !== exp_sclk)
      begin
        $display("[FAIL] symb_clk_o expected %h got %h", exp_sclk, symb_clk);
        cmp_err++;
      end
      // set by the symbol strobe, toggled by the other 2x strobe
      if (symb_en)
        exp_sclk = 1'b1;
      else if (symb_2x)
        exp_sclk = ~exp_sclk;
      if (m_biphase && cout !== eff_stb)
      begin
        $display("[FAIL] cout_o expected %h got %h", eff_stb, cout);
        cmp_err++;
      end
      if (eff_stb)
      begin
        k = m_serial ? n_eff - 6 : n_eff - 4;
        if (k >= m_skip)
        begin
          exp_out = ref_out(k);
          cmp_chk++;
          if (dout_i !== exp_out[0])
          begin
            $display("[FAIL] dout_i_o expected %h got %h at strobe %0d",
                     exp_out[0], dout_i, n_eff);
            cmp_err++;
          end
          if (dout_q !== exp_out[1])
          begin
            $display("[FAIL] dout_q_o expected %h got %h at strobe %0d",
                     exp_out[1], dout_q, n_eff);
            cmp_err++;
          end
        end
        n_eff++;
      end
    end
  end

  // ------------------------------
  // bus and helpers
  // ------------------------------

  task automatic apply_reset();
    rs = 1'b1;
    repeat (4) @(negedge clk);
    rs = 1'b0;
    @(negedge clk);
  endtask

  task automatic bus_write(input logic [12:0] a, input logic [15:0] d,
                           input logic w0, input logic w1);
    @(negedge clk);
    en   = 1'b1;
    addr = a;
    din  = d;
    wr0  = w0;
    wr1  = w1;
    @(negedge clk);
    en  = 1'b0;
    wr0 = 1'b0;
    wr1 = 1'b0;
  endtask

  task automatic bus_read(input logic [12:0] a, output logic [15:0] d);
    @(negedge clk);
    en   = 1'b1;
    addr = a;
    @(posedge clk);
    d = dout;
    @(negedge clk);
    en = 1'b0;
  endtask

  task automatic check_val(input string name, input logic [15:0] got,
                           input logic [15:0] exp_val);
    if (got !== exp_val)
    begin
      $display("[FAIL] %s expected %h got %h", name, exp_val, got);
      reg_err++;
    end
  endtask

  task automatic report(input string name, input int chk, input int err);
    tests_run++;
    if (err != 0)
      tests_failed++;
    $display("test %-14s %0d checks, %0d errors", name, chk, err);
  endtask

  task automatic register_test();
    logic [15:0] rd;
    int          err0;
    err0 = reg_err;
    apply_reset();
    bus_read(ADDR, rd);
    check_val("dout_o", rd, 16'h0000);
    bus_read(13'h0041, rd);
    check_val("dout_o", rd, 16'h0000);
    // low lane only, then high lane only
    bus_write(ADDR, 16'hffff, 1'b1, 1'b0);
    bus_read(ADDR, rd);
    check_val("dout_o", rd, 16'h00ff);
    bus_write(ADDR, 16'h6100, 1'b0, 1'b1);
    bus_read(ADDR, rd);
    check_val("dout_o", rd, 16'h61ff);
    check_val("fifo_rs_o", {15'd0, fifo_rs}, 16'h0001);
    check_val("clk_inv_o", {15'd0, clk_inv}, 16'h0001);
    check_val("bypass_fifo_o", {15'd0, bypass_fifo}, 16'h0001);
    check_val("input_sel_o", {15'd0, input_sel}, 16'h0001);
    // wrong address leaves the register alone
    bus_write(13'h0041, 16'h0000, 1'b1, 1'b1);
    bus_read(13'h0041, rd);
    check_val("dout_o", rd, 16'h0000);
    bus_write(ADDR, 16'h0000, 1'b1, 1'b0);
    bus_read(ADDR, rd);
    check_val("dout_o", rd, 16'h6100);
    check_val("fifo_rs_o", {15'd0, fifo_rs}, 16'h0000);
    check_val("clk_inv_o", {15'd0, clk_inv}, 16'h0000);
    check_val("bypass_fifo_o", {15'd0, bypass_fifo}, 16'h0001);
    check_val("input_sel_o", {15'd0, input_sel}, 16'h0001);
    report("registers", 14, reg_err - err0);
  endtask

  task automatic decode_test(input string name, input logic [15:0] ctl,
                             input int nsym, input int skip, input bit scramble);
    int chk0;
    int err0;
    int target;
    int guard;
    apply_reset();
    bus_write(ADDR, ctl, 1'b1, 1'b1);
    m_mode     = ctl[9:8];
    m_swap     = ctl[6];
    m_inv      = ctl[3];
    m_derand   = ctl[4];
    m_serial   = ctl[5];
    m_biphase  = ctl[7];
    m_scramble = scramble;
    m_skip     = skip;
    chk0       = cmp_chk;
    err0       = cmp_err;
    target     = m_serial ? 2 * nsym : nsym;
    @(negedge clk);
    run_on = 1'b1;
    gen_on = 1'b1;
    guard  = 0;
    while (n_eff < target && guard < 40 * nsym)
    begin
      @(negedge clk);
      guard++;
    end
    if (n_eff < target)
    begin
      $display("timeout: %s saw only %0d of %0d strobes", name, n_eff, target);
      stuck = 1'b1;
      forever @(negedge clk);
    end
    else
    begin
      gen_on = 1'b0;
      run_on = 1'b0;
      @(negedge clk);
      report(name, cmp_chk - chk0, cmp_err - err0);
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial
  begin
    void'($urandom(32'hcae649c8));
    rs         = 1'b1;
    en         = 1'b0;
    wr0        = 1'b0;
    wr1        = 1'b0;
    addr       = 13'h0000;
    din        = 16'h0000;
    gen_on     = 1'b0;
    run_on     = 1'b0;
    cmp_chk    = 0;
    cmp_err    = 0;
    reg_err    = 0;
    m_mode     = 2'd0;
    m_swap     = 1'b0;
    m_inv      = 1'b0;
    m_derand   = 1'b0;
    m_serial   = 1'b0;
    m_biphase  = 1'b0;
    m_scramble = 1'b0;
    m_skip     = 0;
    register_test();
    decode_test("nrz_l", 16'h0000, 120, 0, 1'b0);
    decode_test("nrz_m", 16'h0100, 120, 0, 1'b0);
    decode_test("nrz_s", 16'h0200, 120, 0, 1'b0);
    decode_test("swap", 16'h0040, 100, 0, 1'b0);
    decode_test("swap_inv", 16'h0048, 100, 0, 1'b0);
    decode_test("biphase", 16'h0080, 100, 0, 1'b0);
    decode_test("qpsk_serial", 16'h0020, 100, 0, 1'b0);
    decode_test("derandomize", 16'h0010, 150, 15, 1'b1);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, cmp_chk + 14, cmp_err + reg_err);
    if (tests_failed == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // guard against a stuck run
  initial
  begin
    for (int c = 0; c < WATCHDOG && !stuck; c++)
      @(posedge clk);
    if (stuck)
      $display("decode test stalled waiting for strobes");
    else
      $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule
